/* Makefile */
TOP := tb_pcie_egress

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f filelist.f -o sim

run: build
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -qxF '*** PASSED ***' sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ns \
		--top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* bench/tb_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_monitor
  import pcie_ctrl_pkg::*;
#(
  parameter int DEPTH = 16
)(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  // Expected packets from the stimulus loop
  input  logic     i_exp_push,
  input  word_t    i_exp_word,
  input  logic     i_exp_last,
  input  logic     i_vec_push,
  input  msi_vec_t i_exp_vec,
  input  logic     i_check_end,
  // Watched DUT ports
  input  logic     i_data_stb,
  input  logic     i_data_commit,
  input  logic     i_data_full,
  input  logic     i_tx_ready,
  input  word_t    i_tx_data,
  input  logic     i_tx_valid,
  input  logic     i_tx_last,
  input  logic     i_cfg_interrupt,
  input  msi_vec_t i_cfg_interrupt_di,
  output int       o_errors
);

  // Last flag in bit 32, word below it
  logic [32:0] exp_words [$];
  msi_vec_t    exp_vecs [$];
  logic [32:0] item;
  msi_vec_t    vec;
  logic        exp_full;
  int          err_count = 0;
  int          cyc = 0;
  int          last_cyc = 0;
  int          wr_seen = 0;
  logic        irq_q = 1'b0;

  assign o_errors = err_count;

  always @(posedge clk_62p5) begin
    cyc = cyc + 1;
    if (pcie_reset) begin
      irq_q   = 1'b0;
      wr_seen = 0;
    end else begin
      if (i_exp_push) begin
        exp_words.push_back({i_exp_last, i_exp_word});
      end
      if (i_vec_push) begin
        exp_vecs.push_back(i_exp_vec);
      end

      // Buffer reports full once DEPTH writes were taken
      if (i_data_stb) begin
        exp_full = (wr_seen >= DEPTH);
        if (i_data_full !== exp_full) begin
          $display("FAIL o_data_full: expected %h, got %h", exp_full, i_data_full);
          err_count++;
        end
        if (wr_seen < DEPTH) begin
          wr_seen++;
        end
      end
      if (i_data_commit) begin
        wr_seen = 0;
      end

      if (i_tx_valid && i_tx_ready) begin
        if (exp_words.size() == 0) begin
          $display("unexpected tx word %h while no packet was expected", i_tx_data);
          err_count++;
        end else begin
          item = exp_words.pop_front();
          if (i_tx_data !== item[31:0]) begin
            $display("FAIL o_tx_data: expected %h, got %h", item[31:0], i_tx_data);
            err_count++;
          end
          if (i_tx_last !== item[32]) begin
            $display("FAIL o_tx_last: expected %h, got %h", item[32], i_tx_last);
            err_count++;
          end
        end
        if (i_tx_last) begin
          last_cyc = cyc;
        end
      end

      if (i_cfg_interrupt && !irq_q) begin
        if (exp_vecs.size() == 0) begin
          $display("unexpected interrupt while no packet was pending");
          err_count++;
        end else begin
          vec = exp_vecs.pop_front();
          if (i_cfg_interrupt_di !== vec) begin
            $display("FAIL o_cfg_interrupt_di: expected %h, got %h", vec, i_cfg_interrupt_di);
            err_count++;
          end
        end
        // Raised on the second edge after the last transfer, seen one edge later
        if (cyc - last_cyc != 3) begin
          $display("interrupt rose %0d cycles after the last transfer instead of 2",
                   cyc - last_cyc - 1);
          err_count++;
        end
      end
      irq_q = i_cfg_interrupt;

      if (i_check_end && (exp_words.size() != 0 || exp_vecs.size() != 0)) begin
        $display("missing packet: %0d words and %0d interrupts never seen",
                 exp_words.size(), exp_vecs.size());
        err_count++;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tb_pcie_egress.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_egress
  import pcie_ctrl_pkg::*;
();

  localparam int BUF_DEPTH_LOG2 = 4;
  localparam int DEPTH          = 2 ** BUF_DEPTH_LOG2;
  localparam int NUM_ROWS       = 7;
  localparam int TIMEOUT_CYCLES = 500;

  typedef enum logic [1:0] {
    K_PING,
    K_DATA,
    K_BOTH
  } kind_t;

  logic     clk_62p5 = 1'b0;
  logic     pcie_reset;
  logic     ping_stb;
  word_t    ping_value;
  logic     data_stb;
  word_t    wr_data;
  logic     data_commit;
  logic     data_full;
  logic     tx_ready = 1'b1;
  word_t    tx_data;
  logic     tx_valid;
  logic     tx_last;
  logic     cfg_interrupt;
  msi_vec_t cfg_interrupt_di;
  logic     cfg_interrupt_rdy;

  // Expected values handed to the monitor
  logic     exp_push;
  word_t    exp_word;
  logic     exp_last;
  logic     vec_push;
  msi_vec_t exp_vec;
  logic     check_end;
  int       mon_errors;

  // One stimulus row per packet
  // Value holds the ping value or the first data word
  kind_t row_kind  [NUM_ROWS];
  int    row_count [NUM_ROWS];
  word_t row_value [NUM_ROWS];
  bit    row_bp    [NUM_ROWS];

  int   seed;
  int   rnd;
  bit   bp_on;
  tag_t exp_tag;
  int   timeouts;
  int   assert_errors;

  always #4 clk_62p5 = ~clk_62p5;

  // Random sink stall when the row asks for it
  always @(posedge clk_62p5) begin
    if (bp_on) begin
      rnd = $random(seed);
    end else begin
      rnd = 1;
    end
    #1;
    tx_ready = rnd[0];
  end

  pcie_egress_top #(
    .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
  ) dut0 (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_cmd_ping_stb      (ping_stb),
    .i_ping_value        (ping_value),
    .i_data_stb          (data_stb),
    .i_data              (wr_data),
    .i_data_commit       (data_commit),
    .o_data_full         (data_full),
    .i_tx_ready          (tx_ready),
    .o_tx_data           (tx_data),
    .o_tx_valid          (tx_valid),
    .o_tx_last           (tx_last),
    .o_cfg_interrupt     (cfg_interrupt),
    .o_cfg_interrupt_di  (cfg_interrupt_di),
    .i_cfg_interrupt_rdy (cfg_interrupt_rdy)
  );

  tb_monitor #(
    .DEPTH (DEPTH)
  ) mon0 (
    .clk_62p5           (clk_62p5),
    .pcie_reset         (pcie_reset),
    .i_exp_push         (exp_push),
    .i_exp_word         (exp_word),
    .i_exp_last         (exp_last),
    .i_vec_push         (vec_push),
    .i_exp_vec          (exp_vec),
    .i_check_end        (check_end),
    .i_data_stb         (data_stb),
    .i_data_commit      (data_commit),
    .i_data_full        (data_full),
    .i_tx_ready         (tx_ready),
    .i_tx_data          (tx_data),
    .i_tx_valid         (tx_valid),
    .i_tx_last          (tx_last),
    .i_cfg_interrupt    (cfg_interrupt),
    .i_cfg_interrupt_di (cfg_interrupt_di),
    .o_errors           (mon_errors)
  );

  task automatic set_row(input int r, input kind_t kind, input int count,
                         input word_t value, input bit bp);
    row_kind[r]  = kind;
    row_count[r] = count;
    row_value[r] = value;
    row_bp[r]    = bp;
  endtask

  // Every driver below runs 1 ns after a rising edge
  task automatic next_cycle();
    @(posedge clk_62p5);
    #1;
  endtask

  // Header, payload words and MSI vector of one packet
  task automatic expect_packet(input int len, input bit is_ping, input word_t value);
    int i;
    exp_push = 1'b1;
    exp_word = {TLP_CMD_MEM_WR, exp_tag, 6'b0, tlp_len_t'(len)};
    exp_last = 1'b0;
    next_cycle();
    for (i = 0; i < len; i++) begin
      if (is_ping) begin
        exp_word = (i == 0) ? RESP_PING_ACK : value;
      end else begin
        exp_word = value + i;
      end
      exp_last = (i == len - 1);
      next_cycle();
    end
    exp_push = 1'b0;
    vec_push = 1'b1;
    exp_vec  = is_ping ? MSI_VEC_CTRL : MSI_VEC_DATA;
    next_cycle();
    vec_push = 1'b0;
    exp_tag  = exp_tag + 8'd1;
  endtask

  task automatic write_block(input int count, input word_t first);
    int i;
    for (i = 0; i < count; i++) begin
      data_stb = 1'b1;
      wr_data  = first + i;
      next_cycle();
    end
    data_stb = 1'b0;
  endtask

  task automatic fire(input bit ping, input bit commit, input word_t value);
    ping_stb    = ping;
    ping_value  = value;
    data_commit = commit;
    next_cycle();
    ping_stb    = 1'b0;
    data_commit = 1'b0;
  endtask

  task automatic wait_irq(input bit level, input int row);
    int n;
    n = 0;
    while (cfg_interrupt !== level && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (cfg_interrupt !== level) begin
      $display("timeout in row %0d: interrupt never went %s", row, level ? "high" : "low");
      timeouts++;
    end
  endtask

  task automatic answer_irq(input int row);
    wait_irq(1'b1, row);
    repeat (3) next_cycle();
    cfg_interrupt_rdy = 1'b1;
    next_cycle();
    cfg_interrupt_rdy = 1'b0;
    wait_irq(1'b0, row);
  endtask

  initial begin
    int r;
    int len;
    seed              = 35570;
    pcie_reset        = 1'b1;
    ping_stb          = 1'b0;
    ping_value        = '0;
    data_stb          = 1'b0;
    wr_data           = '0;
    data_commit       = 1'b0;
    cfg_interrupt_rdy = 1'b0;
    exp_push          = 1'b0;
    exp_word          = '0;
    exp_last          = 1'b0;
    vec_push          = 1'b0;
    exp_vec           = '0;
    check_end         = 1'b0;
    bp_on             = 1'b0;
    exp_tag           = '0;
    timeouts          = 0;

    set_row(0, K_PING, 0,  32'hCAFE_0001, 1'b0);
    set_row(1, K_DATA, 4,  32'h1000_0000, 1'b0);
    set_row(2, K_DATA, 9,  32'h2000_0000, 1'b1);
    set_row(3, K_PING, 0,  32'hDEAD_BEEF, 1'b1);
    // More words than the buffer holds
    set_row(4, K_DATA, 20, 32'h3000_0000, 1'b0);
    // Ping and commit land together
    set_row(5, K_BOTH, 6,  32'h4000_0000, 1'b0);
    set_row(6, K_DATA, 1,  32'h5000_0000, 1'b1);

    repeat (2) @(posedge clk_62p5);
    #1;
    pcie_reset = 1'b0;
    next_cycle();

    for (r = 0; r < NUM_ROWS; r++) begin
      bp_on = row_bp[r];
      len   = (row_count[r] < DEPTH) ? row_count[r] : DEPTH;
      if (row_kind[r] != K_DATA) begin
        expect_packet(2, 1'b1, row_value[r]);
      end
      if (row_kind[r] != K_PING) begin
        expect_packet(len, 1'b0, row_value[r]);
        write_block(row_count[r], row_value[r]);
      end
      fire(row_kind[r] != K_DATA, row_kind[r] != K_PING, row_value[r]);
      answer_irq(r);
      if (row_kind[r] == K_BOTH) begin
        answer_irq(r);
      end
    end

    bp_on     = 1'b0;
    check_end = 1'b1;
    next_cycle();
    check_end = 1'b0;
    next_cycle();
    assert_errors = dut0.egress0.asserts0.fail_count + dut0.msi0.asserts0.fail_count;
    $display("errors: %0d compare, %0d timeout, %0d assertion",
             mon_errors, timeouts, assert_errors);
    if (mon_errors == 0 && timeouts == 0 && assert_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_pcie_egress_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pcie_egress_asserts
  import pcie_ctrl_pkg::*;
(
  input logic  clk_62p5,
  input logic  pcie_reset,
  input logic  i_tx_valid,
  input logic  i_tx_ready,
  input word_t i_tx_data,
  input logic  i_cfg_interrupt,
  input logic  i_cfg_interrupt_rdy
);

  int fail_count = 0;

  // Offered word stays put until the sink takes it
  tx_hold: assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
    else begin
      fail_count++;
      $error("tx word changed or dropped under back-pressure");
    end

  irq_release: assert property (@(posedge clk_62p5) disable iff (pcie_reset)
    (i_cfg_interrupt && i_cfg_interrupt_rdy) |=> !i_cfg_interrupt)
    else begin
      fail_count++;
      $error("interrupt still high the cycle after ready");
    end

  // Stream idle on the first cycle out of reset
  reset_idle: assert property (@(posedge clk_62p5)
    $fell(pcie_reset) |-> !i_tx_valid)
    else begin
      fail_count++;
      $error("tx valid high right after reset");
    end

endmodule

bind tlp_egress tb_pcie_egress_asserts asserts0 (
  .clk_62p5            (clk_62p5),
  .pcie_reset          (pcie_reset),
  .i_tx_valid          (o_tx_valid),
  .i_tx_ready          (i_tx_ready),
  .i_tx_data           (o_tx_data),
  .i_cfg_interrupt     (1'b0),
  .i_cfg_interrupt_rdy (1'b0)
);

bind msi_requester tb_pcie_egress_asserts asserts0 (
  .clk_62p5            (clk_62p5),
  .pcie_reset          (pcie_reset),
  .i_tx_valid          (1'b0),
  .i_tx_ready          (1'b0),
  .i_tx_data           (32'h0),
  .i_cfg_interrupt     (o_cfg_interrupt),
  .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy)
);

`default_nettype wire

/* filelist.f */
verilog/pcie_ctrl_pkg.sv
verilog/block_buffer.sv
verilog/ctrl_responder.sv
verilog/egress_arbiter.sv
verilog/tlp_egress.sv
verilog/msi_requester.sv
verilog/pcie_egress_top.sv
bench/tb_pcie_egress_asserts.sv
bench/tb_monitor.sv
bench/tb_pcie_egress.sv

/* verilog/block_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module block_buffer
  import pcie_ctrl_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 4
)(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  input  logic     i_wr_stb,
  input  word_t    i_wr_data,
  input  logic     i_commit,
  output logic     o_full,
  output logic     o_rd_rdy,
  input  logic     i_rd_act,
  output tlp_len_t o_rd_size,
  input  logic     i_rd_stb,
  output word_t    o_rd_data
);

  localparam int DEPTH = 2 ** BUF_DEPTH_LOG2;

  word_t                   mem [DEPTH];
  logic [BUF_DEPTH_LOG2:0] wr_cnt;
  logic [BUF_DEPTH_LOG2-1:0] rd_ptr;
  logic                    committed;
  logic                    reading;
  logic                    wr_en;

  // Count hits DEPTH only once every address holds a word
  assign o_full = wr_cnt[BUF_DEPTH_LOG2];
  assign wr_en  = i_wr_stb && !committed && !o_full;

  always_ff @(posedge clk_62p5) begin
    if (wr_en) begin
      mem[wr_cnt[BUF_DEPTH_LOG2-1:0]] <= i_wr_data;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      wr_cnt    <= '0;
      rd_ptr    <= '0;
      committed <= 1'b0;
      reading   <= 1'b0;
    end else if (committed) begin
      if (reading && !i_rd_act) begin
        // Reader let go, buffer is free for the next block
        wr_cnt    <= '0;
        rd_ptr    <= '0;
        committed <= 1'b0;
        reading   <= 1'b0;
      end else begin
        if (i_rd_act) begin
          reading <= 1'b1;
        end
        if (i_rd_act && i_rd_stb) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end else begin
      if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      // Empty block is never offered
      if (i_commit && (wr_en || wr_cnt != '0)) begin
        committed <= 1'b1;
      end
    end
  end

  assign o_rd_rdy  = committed && !reading;
  assign o_rd_size = tlp_len_t'(wr_cnt);
  // First word fall through
  assign o_rd_data = mem[rd_ptr];

endmodule

`default_nettype wire

/* verilog/ctrl_responder.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_responder
  import pcie_ctrl_pkg::*;
(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  input  logic     i_cmd_ping_stb,
  input  word_t    i_ping_value,
  output logic     o_rd_rdy,
  input  logic     i_rd_act,
  output tlp_len_t o_rd_size,
  input  logic     i_rd_stb,
  output word_t    o_rd_data
);

  localparam tlp_len_t RESP_LEN = 10'd2;

  logic  pending;
  logic  reading;
  logic  word_idx;
  word_t ping_val;

  always_ff @(posedge clk_62p5) begin
    if (i_cmd_ping_stb && !pending) begin
      ping_val <= i_ping_value;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      pending  <= 1'b0;
      reading  <= 1'b0;
      word_idx <= 1'b0;
    end else if (!pending) begin
      // Pings only land when no response is waiting
      if (i_cmd_ping_stb) begin
        pending  <= 1'b1;
        word_idx <= 1'b0;
      end
    end else if (reading && !i_rd_act) begin
      pending <= 1'b0;
      reading <= 1'b0;
    end else begin
      if (i_rd_act) begin
        reading <= 1'b1;
      end
      if (i_rd_act && i_rd_stb) begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  assign o_rd_rdy  = pending && !reading;
  assign o_rd_size = RESP_LEN;
  // Ack word, then echo of the ping value
  assign o_rd_data = word_idx ? ping_val : RESP_PING_ACK;

endmodule

`default_nettype wire

/* verilog/egress_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module egress_arbiter
  import pcie_ctrl_pkg::*;
(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  // Control source
  input  logic     i_ctrl_rdy,
  input  tlp_len_t i_ctrl_size,
  input  word_t    i_ctrl_data,
  output logic     o_ctrl_act,
  output logic     o_ctrl_stb,
  // User data source
  input  logic     i_dat_rdy,
  input  tlp_len_t i_dat_size,
  input  word_t    i_dat_data,
  output logic     o_dat_act,
  output logic     o_dat_stb,
  // Egress engine
  output logic     o_eg_rdy,
  output tlp_len_t o_eg_size,
  output word_t    o_eg_data,
  input  logic     i_eg_act,
  input  logic     i_eg_stb,
  output src_t     o_eg_src
);

  logic granted;
  src_t grant_src;
  logic act_q;
  logic sel_ctrl;
  logic sel_dat;

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      granted   <= 1'b0;
      grant_src <= SRC_CTRL;
      act_q     <= 1'b0;
    end else begin
      act_q <= i_eg_act;
      if (!granted) begin
        // Control traffic wins a tie
        if (i_ctrl_rdy) begin
          granted   <= 1'b1;
          grant_src <= SRC_CTRL;
        end else if (i_dat_rdy) begin
          granted   <= 1'b1;
          grant_src <= SRC_DATA;
        end
      end else if (act_q && !i_eg_act) begin
        granted <= 1'b0;
      end
    end
  end

  assign sel_ctrl = granted && (grant_src == SRC_CTRL);
  assign sel_dat  = granted && (grant_src == SRC_DATA);

  assign o_eg_rdy  = (sel_ctrl && i_ctrl_rdy) || (sel_dat && i_dat_rdy);
  assign o_eg_size = sel_ctrl ? i_ctrl_size : i_dat_size;
  assign o_eg_data = sel_ctrl ? i_ctrl_data : i_dat_data;
  assign o_eg_src  = grant_src;

  assign o_ctrl_act = sel_ctrl && i_eg_act;
  assign o_ctrl_stb = sel_ctrl && i_eg_stb;
  assign o_dat_act  = sel_dat && i_eg_act;
  assign o_dat_stb  = sel_dat && i_eg_stb;

endmodule

`default_nettype wire

/* verilog/msi_requester.sv */
`timescale 1ns/1ns
`default_nettype none

module msi_requester
  import pcie_ctrl_pkg::*;
(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  input  logic     i_finished,
  input  src_t     i_finished_src,
  output logic     o_cfg_interrupt,
  output msi_vec_t o_cfg_interrupt_di,
  input  logic     i_cfg_interrupt_rdy
);

  msi_state_t state;

  always_ff @(posedge clk_62p5) begin
    if (i_finished && state == MSI_IDLE) begin
      o_cfg_interrupt_di <= (i_finished_src == SRC_CTRL) ? MSI_VEC_CTRL : MSI_VEC_DATA;
    end
  end

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state           <= MSI_IDLE;
      o_cfg_interrupt <= 1'b0;
    end else begin
      case (state)
        MSI_IDLE: begin
          o_cfg_interrupt <= 1'b0;
          if (i_finished) begin
            state <= MSI_SEND;
          end
        end
        MSI_SEND: begin
          // Core only takes the request once it is on the line
          if (o_cfg_interrupt && i_cfg_interrupt_rdy) begin
            o_cfg_interrupt <= 1'b0;
            state           <= MSI_IDLE;
          end else begin
            o_cfg_interrupt <= 1'b1;
          end
        end
        default: begin
          state <= MSI_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/pcie_ctrl_pkg.sv */
`default_nettype none

package pcie_ctrl_pkg;

  // Egress datapath widths
  typedef logic [31:0] word_t;
  typedef logic [9:0]  tlp_len_t;
  typedef logic [7:0]  tag_t;
  typedef logic [7:0]  msi_vec_t;

  // Which block source owns the egress engine
  typedef enum logic {
    SRC_CTRL = 1'b0,
    SRC_DATA = 1'b1
  } src_t;

  typedef enum logic [1:0] {
    EG_IDLE,
    EG_HEADER,
    EG_DATA,
    EG_DONE
  } egress_state_t;

  typedef enum logic {
    MSI_IDLE,
    MSI_SEND
  } msi_state_t;

  // Command byte of the header word, bits 31:24
  localparam logic [7:0] TLP_CMD_MEM_WR = 8'h40;
  // ASCII "PING", first word of a ping response
  localparam word_t      RESP_PING_ACK  = 32'h5049_4E47;
  localparam msi_vec_t   MSI_VEC_CTRL   = 8'd0;
  localparam msi_vec_t   MSI_VEC_DATA   = 8'd1;

endpackage

`default_nettype wire

/* verilog/pcie_egress_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pcie_egress_top
  import pcie_ctrl_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 4
)(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  input  logic     i_cmd_ping_stb,
  input  word_t    i_ping_value,
  input  logic     i_data_stb,
  input  word_t    i_data,
  input  logic     i_data_commit,
  output logic     o_data_full,
  input  logic     i_tx_ready,
  output word_t    o_tx_data,
  output logic     o_tx_valid,
  output logic     o_tx_last,
  output logic     o_cfg_interrupt,
  output msi_vec_t o_cfg_interrupt_di,
  input  logic     i_cfg_interrupt_rdy
);

  logic     ctrl_rdy, ctrl_act, ctrl_stb;
  tlp_len_t ctrl_size;
  word_t    ctrl_data;
  logic     dat_rdy, dat_act, dat_stb;
  tlp_len_t dat_size;
  word_t    dat_data;
  logic     eg_rdy, eg_act, eg_stb;
  tlp_len_t eg_size;
  word_t    eg_data;
  src_t     eg_src;
  logic     finished;
  src_t     finished_src;

  ctrl_responder ctrl0 (
    .clk_62p5       (clk_62p5),
    .pcie_reset     (pcie_reset),
    .i_cmd_ping_stb (i_cmd_ping_stb),
    .i_ping_value   (i_ping_value),
    .o_rd_rdy       (ctrl_rdy),
    .i_rd_act       (ctrl_act),
    .o_rd_size      (ctrl_size),
    .i_rd_stb       (ctrl_stb),
    .o_rd_data      (ctrl_data)
  );

  block_buffer #(
    .BUF_DEPTH_LOG2 (BUF_DEPTH_LOG2)
  ) buf0 (
    .clk_62p5   (clk_62p5),
    .pcie_reset (pcie_reset),
    .i_wr_stb   (i_data_stb),
    .i_wr_data  (i_data),
    .i_commit   (i_data_commit),
    .o_full     (o_data_full),
    .o_rd_rdy   (dat_rdy),
    .i_rd_act   (dat_act),
    .o_rd_size  (dat_size),
    .i_rd_stb   (dat_stb),
    .o_rd_data  (dat_data)
  );

  egress_arbiter arb0 (
    .clk_62p5    (clk_62p5),
    .pcie_reset  (pcie_reset),
    .i_ctrl_rdy  (ctrl_rdy),
    .i_ctrl_size (ctrl_size),
    .i_ctrl_data (ctrl_data),
    .o_ctrl_act  (ctrl_act),
    .o_ctrl_stb  (ctrl_stb),
    .i_dat_rdy   (dat_rdy),
    .i_dat_size  (dat_size),
    .i_dat_data  (dat_data),
    .o_dat_act   (dat_act),
    .o_dat_stb   (dat_stb),
    .o_eg_rdy    (eg_rdy),
    .o_eg_size   (eg_size),
    .o_eg_data   (eg_data),
    .i_eg_act    (eg_act),
    .i_eg_stb    (eg_stb),
    .o_eg_src    (eg_src)
  );

  tlp_egress egress0 (
    .clk_62p5       (clk_62p5),
    .pcie_reset     (pcie_reset),
    .i_rdy          (eg_rdy),
    .i_size         (eg_size),
    .i_data         (eg_data),
    .i_src          (eg_src),
    .o_act          (eg_act),
    .o_stb          (eg_stb),
    .i_tx_ready     (i_tx_ready),
    .o_tx_data      (o_tx_data),
    .o_tx_valid     (o_tx_valid),
    .o_tx_last      (o_tx_last),
    .o_finished     (finished),
    .o_finished_src (finished_src)
  );

  msi_requester msi0 (
    .clk_62p5            (clk_62p5),
    .pcie_reset          (pcie_reset),
    .i_finished          (finished),
    .i_finished_src      (finished_src),
    .o_cfg_interrupt     (o_cfg_interrupt),
    .o_cfg_interrupt_di  (o_cfg_interrupt_di),
    .i_cfg_interrupt_rdy (i_cfg_interrupt_rdy)
  );

endmodule

`default_nettype wire

/* verilog/tlp_egress.sv */
`timescale 1ns/1ns
`default_nettype none

module tlp_egress
  import pcie_ctrl_pkg::*;
(
  input  logic     clk_62p5,
  input  logic     pcie_reset,
  // Block read side, through the arbiter
  input  logic     i_rdy,
  input  tlp_len_t i_size,
  input  word_t    i_data,
  input  src_t     i_src,
  output logic     o_act,
  output logic     o_stb,
  // Transmit stream
  input  logic     i_tx_ready,
  output word_t    o_tx_data,
  output logic     o_tx_valid,
  output logic     o_tx_last,
  // Packet done
  output logic     o_finished,
  output src_t     o_finished_src
);

  egress_state_t state;
  tag_t          tag;
  tlp_len_t      word_cnt;
  word_t         header;

  always_ff @(posedge clk_62p5) begin
    if (pcie_reset) begin
      state    <= EG_IDLE;
      tag      <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        EG_IDLE: begin
          if (i_rdy) begin
            state    <= EG_HEADER;
            word_cnt <= '0;
          end
        end
        EG_HEADER: begin
          if (i_tx_ready) begin
            state <= EG_DATA;
          end
        end
        EG_DATA: begin
          if (i_tx_ready) begin
            word_cnt <= word_cnt + 1'b1;
            if (o_tx_last) begin
              state <= EG_DONE;
            end
          end
        end
        EG_DONE: begin
          // Tag wraps at 256
          tag   <= tag + 1'b1;
          state <= EG_IDLE;
        end
        default: begin
          state <= EG_IDLE;
        end
      endcase
    end
  end

  // Command, tag, six zero bits, length
  assign header = {TLP_CMD_MEM_WR, tag, 6'b0, i_size};

  // Block stays held over the header cycle as well
  assign o_act      = (state == EG_HEADER) || (state == EG_DATA);
  assign o_tx_valid = o_act;
  assign o_tx_data  = (state == EG_HEADER) ? header : i_data;
  assign o_tx_last  = (state == EG_DATA) && (word_cnt == i_size - 1'b1);

  // Source word only moves when the current one is taken
  assign o_stb = (state == EG_DATA) && i_tx_ready;

  assign o_finished     = (state == EG_DONE);
  assign o_finished_src = i_src;

endmodule

`default_nettype wire
